/* design/mem_test_pkg.sv */
//--------------------------------------
// shared types and DDR address layout for the memory tester
// address is {cs, row, bank, col, 2'b00}, one chip-select bit only
//--------------------------------------
package mem_test_pkg;

	//--------------------------------------
	// enums
	//--------------------------------------
	// controller states, write pass then read pass
	typedef enum logic [2:0]
	{
		IDLE,
		WR_ADDR,
		WR_RESP,
		RD_ADDR,
		RD_DATA,
		DONE
	} test_state_e;

	// kind of the first error seen
	typedef enum logic [1:0]
	{
		ERR_NONE,
		ERR_DATA,
		ERR_WRESP,
		ERR_RRESP
	} err_kind_e;

	// AXI bresp / rresp codes
	typedef enum logic [1:0]
	{
		OKAY,
		EXOKAY,
		SLVERR,
		DECERR
	} axi_resp_e;

	//--------------------------------------
	// address fields
	//--------------------------------------
	localparam int ADDR_W = 33;
	localparam int ROW_W  = 17;
	localparam int BANK_W = 3;
	localparam int COL_W  = 10;
	// beat index = cs + row + bank + col
	localparam int BEAT_W = 1 + ROW_W + BANK_W + COL_W;

endpackage

/* design/mem_addr_gen.sv */
//--------------------------------------
// beat counter to DDR byte address, range is inclusive
// interleave 1 puts the bank bits lowest
//--------------------------------------
`timescale 1ns/10ps

module mem_addr_gen #(
	parameter int P_START_BEAT      = 0,
	parameter int P_STOP_BEAT       = 1023,
	parameter int P_BANK_INTERLEAVE = 0
)(
	input  logic                            iACLK,
	input  logic                            iARST,
	input  logic                            i_restart,
	input  logic                            i_step,
	output logic [mem_test_pkg::ADDR_W-1:0] o_addr,
	output logic                            o_last_beat
);

	localparam int BW     = mem_test_pkg::BEAT_W;
	localparam int ROW_W  = mem_test_pkg::ROW_W;
	localparam int BANK_W = mem_test_pkg::BANK_W;
	localparam int COL_W  = mem_test_pkg::COL_W;
	localparam logic [BW-1:0] L_START = BW'(P_START_BEAT);
	localparam logic [BW-1:0] L_STOP  = BW'(P_STOP_BEAT);

	logic [BW-1:0]     r_beat;
	logic              cs;
	logic [ROW_W-1:0]  row;
	logic [BANK_W-1:0] bank;
	logic [COL_W-1:0]  col;

	// restart wins over step
	always_ff @(posedge iACLK)
	begin
		if (iARST || i_restart)
			r_beat <= L_START;
		else if (i_step)
			r_beat <= r_beat + 1'b1;
	end

	//--------------------------------------
	// field mapping
	//--------------------------------------
	generate
		if (P_BANK_INTERLEAVE != 0)
		begin : g_interleave
			// consecutive beats hit different banks
			assign bank = r_beat[BANK_W-1:0];
			assign col  = r_beat[BANK_W +: COL_W];
		end
		else
		begin : g_linear
			assign col  = r_beat[COL_W-1:0];
			assign bank = r_beat[COL_W +: BANK_W];
		end
	endgenerate

	assign row = r_beat[COL_W+BANK_W +: ROW_W];
	assign cs  = r_beat[BW-1];

	// low two bits are the datapath offset
	assign o_addr      = {cs, row, bank, col, 2'b00};
	assign o_last_beat = (r_beat == L_STOP);

	// the top must gate the step on the last beat
	a_no_overrun: assert property (@(posedge iACLK) disable iff (iARST)
		i_step && !i_restart |-> r_beat != L_STOP);

endmodule

/* design/mem_pattern_gen.sv */
//--------------------------------------
// 32-bit Galois LFSR, seed must be nonzero
// data is the low P_DATA_W bits, P_DATA_W up to 32
//--------------------------------------
`timescale 1ns/10ps

module mem_pattern_gen #(
	parameter int          P_DATA_W = 16,
	parameter logic [31:0] P_SEED   = 32'h0000_ace1
)(
	input  logic                iACLK,
	input  logic                iARST,
	input  logic                i_restart,
	input  logic                i_step,
	output logic [P_DATA_W-1:0] o_data
);

	// taps 32, 22, 2, 1
	localparam logic [31:0] L_TAPS = 32'h8020_0003;

	logic [31:0] r_lfsr;
	logic [31:0] lfsr_next;

	//--------------------------------------
	// next state
	//--------------------------------------
	always_comb
	begin
		// shift right, fold taps in on a shifted-out one
		lfsr_next = r_lfsr >> 1;
		if (r_lfsr[0])
			lfsr_next = lfsr_next ^ L_TAPS;
	end

	// same seed on every pass so reads regenerate the writes
	always_ff @(posedge iACLK)
	begin
		if (iARST || i_restart)
			r_lfsr <= P_SEED;
		else if (i_step)
			r_lfsr <= lfsr_next;
	end

	assign o_data = r_lfsr[P_DATA_W-1:0];

	// all-zero state would lock the pattern
	a_nonzero: assert property (@(posedge iACLK) disable iff (iARST)
		i_step |=> r_lfsr != 32'd0);

endmodule

/* design/mem_read_check.sv */
//--------------------------------------
// compares in the strobe cycle, first error only is kept
// a bad response beats a data compare
//--------------------------------------
`timescale 1ns/10ps

module mem_read_check #(
	parameter int P_DATA_W = 16
)(
	input  logic                            iACLK,
	input  logic                            iARST,
	input  logic                            i_bresp_take,
	input  logic [1:0]                      i_bresp,
	input  logic                            i_rdata_take,
	input  logic [1:0]                      i_rresp,
	input  logic [P_DATA_W-1:0]             i_rdata,
	input  logic [P_DATA_W-1:0]             i_exp_data,
	input  logic [mem_test_pkg::ADDR_W-1:0] i_addr,
	output logic                            o_err,
	output mem_test_pkg::err_kind_e         o_err_kind,
	output logic [mem_test_pkg::ADDR_W-1:0] o_err_addr,
	output logic [P_DATA_W-1:0]             o_err_exp,
	output logic [P_DATA_W-1:0]             o_err_act
);

	mem_test_pkg::err_kind_e err_now;
	mem_test_pkg::err_kind_e r_kind;

	//--------------------------------------
	// classify current strobe
	//--------------------------------------
	always_comb
	begin
		err_now = mem_test_pkg::ERR_NONE;
		if (i_bresp_take && (i_bresp != mem_test_pkg::OKAY))
			err_now = mem_test_pkg::ERR_WRESP;
		else if (i_rdata_take)
		begin
			// data only trusted with OKAY
			if (i_rresp != mem_test_pkg::OKAY)
				err_now = mem_test_pkg::ERR_RRESP;
			else if (i_rdata != i_exp_data)
				err_now = mem_test_pkg::ERR_DATA;
		end
	end

	assign o_err = (err_now != mem_test_pkg::ERR_NONE);

	// kind, held from the first error
	always_ff @(posedge iACLK)
	begin
		if (iARST)
			r_kind <= mem_test_pkg::ERR_NONE;
		else if (o_err && (r_kind == mem_test_pkg::ERR_NONE))
			r_kind <= err_now;
	end

	// record of the failing beat
	always_ff @(posedge iACLK)
	begin
		if (o_err && (r_kind == mem_test_pkg::ERR_NONE))
		begin
			o_err_addr <= i_addr;
			o_err_exp  <= i_exp_data;
			o_err_act  <= i_rdata;
		end
	end

	assign o_err_kind = r_kind;

endmodule

/* design/mem_test_ctrl.sv */
//--------------------------------------
// single-beat AXI write pass, then read pass, no outstanding transfers
// stops at first error; DONE holds until reset
//--------------------------------------
`timescale 1ns/10ps

module mem_test_ctrl #(
	parameter int P_START_BEAT = 0,
	parameter int P_STOP_BEAT  = 1023
)(
	input  logic iACLK,
	input  logic iARST,
	input  logic i_cfg_done,
	input  logic i_awready,
	input  logic i_wready,
	input  logic i_bvalid,
	input  logic i_arready,
	input  logic i_rvalid,
	input  logic i_last_beat,
	input  logic i_err,
	output logic o_awvalid,
	output logic o_wvalid,
	output logic o_bready,
	output logic o_arvalid,
	output logic o_rready,
	output logic o_step_wr,
	output logic o_bresp_take,
	output logic o_rdata_take,
	output logic o_restart,
	output logic o_test_run,
	output logic o_test_done,
	output logic o_test_fail
);

	localparam int BW = mem_test_pkg::BEAT_W;
	// beats per pass minus one
	localparam logic [BW-1:0] L_LAST_CNT = BW'(P_STOP_BEAT - P_START_BEAT);

	mem_test_pkg::test_state_e r_state;
	// aw / w already accepted in this write
	logic r_aw_sent;
	logic r_w_sent;
	logic r_run;
	logic r_done;
	logic r_fail;
	// completed beats in the current pass
	logic [BW-1:0] r_beat_cnt;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic go_done;

	//--------------------------------------
	// handshakes
	//--------------------------------------
	assign o_awvalid = (r_state == mem_test_pkg::WR_ADDR) && !r_aw_sent;
	assign o_wvalid  = (r_state == mem_test_pkg::WR_ADDR) && !r_w_sent;
	assign o_bready  = (r_state == mem_test_pkg::WR_RESP);
	assign o_arvalid = (r_state == mem_test_pkg::RD_ADDR);
	assign o_rready  = (r_state == mem_test_pkg::RD_DATA);

	assign aw_fire = o_awvalid && i_awready;
	assign w_fire  = o_wvalid && i_wready;
	assign ar_fire = o_arvalid && i_arready;

	// both halves of the write done, either order
	assign o_step_wr = (r_state == mem_test_pkg::WR_ADDR)
		&& (r_aw_sent || aw_fire) && (r_w_sent || w_fire);
	assign o_bresp_take = o_bready && i_bvalid;
	assign o_rdata_take = o_rready && i_rvalid;

	// reload generators at start of write pass and of read pass
	assign o_restart = ((r_state == mem_test_pkg::IDLE) && i_cfg_done)
		|| (o_bresp_take && i_last_beat && !i_err);

	// error ends the test, or last read beat
	assign go_done = (o_bresp_take && i_err) || (o_rdata_take && (i_err || i_last_beat));

	//--------------------------------------
	// state machine
	//--------------------------------------
	always_ff @(posedge iACLK)
	begin
		if (iARST)
		begin
			r_state    <= mem_test_pkg::IDLE;
			r_aw_sent  <= 1'b0;
			r_w_sent   <= 1'b0;
			r_beat_cnt <= '0;
		end
		else
		begin
			case (r_state)
				mem_test_pkg::IDLE:
				begin
					if (i_cfg_done)
					begin
						r_state    <= mem_test_pkg::WR_ADDR;
						r_beat_cnt <= '0;
					end
				end
				mem_test_pkg::WR_ADDR:
				begin
					if (o_step_wr)
					begin
						r_state   <= mem_test_pkg::WR_RESP;
						r_aw_sent <= 1'b0;
						r_w_sent  <= 1'b0;
					end
					else
					begin
						if (aw_fire)
							r_aw_sent <= 1'b1;
						if (w_fire)
							r_w_sent <= 1'b1;
					end
				end
				mem_test_pkg::WR_RESP:
				begin
					if (o_bresp_take)
					begin
						if (i_err)
							r_state <= mem_test_pkg::DONE;
						else if (i_last_beat)
						begin
							r_state    <= mem_test_pkg::RD_ADDR;
							r_beat_cnt <= '0;
						end
						else
						begin
							r_state    <= mem_test_pkg::WR_ADDR;
							r_beat_cnt <= r_beat_cnt + 1'b1;
						end
					end
				end
				mem_test_pkg::RD_ADDR:
				begin
					if (ar_fire)
						r_state <= mem_test_pkg::RD_DATA;
				end
				mem_test_pkg::RD_DATA:
				begin
					if (go_done)
						r_state <= mem_test_pkg::DONE;
					else if (o_rdata_take)
					begin
						r_state    <= mem_test_pkg::RD_ADDR;
						r_beat_cnt <= r_beat_cnt + 1'b1;
					end
				end
				mem_test_pkg::DONE:
					r_state <= mem_test_pkg::DONE;
				default:
					r_state <= mem_test_pkg::IDLE;
			endcase
		end
	end

	//--------------------------------------
	// status levels
	//--------------------------------------
	always_ff @(posedge iACLK)
	begin
		if (iARST)
		begin
			r_run  <= 1'b0;
			r_done <= 1'b0;
			r_fail <= 1'b0;
		end
		else if (go_done)
		begin
			r_run  <= 1'b0;
			r_done <= 1'b1;
			r_fail <= i_err;
		end
		else if ((r_state == mem_test_pkg::IDLE) && i_cfg_done)
			r_run <= 1'b1;
	end

	assign o_test_run  = r_run;
	assign o_test_done = r_done;
	assign o_test_fail = r_fail;

	// valids stay up until accepted
	a_aw_hold: assert property (@(posedge iACLK) disable iff (iARST)
		o_awvalid && !i_awready |=> o_awvalid);
	a_w_hold: assert property (@(posedge iACLK) disable iff (iARST)
		o_wvalid && !i_wready |=> o_wvalid);
	a_ar_hold: assert property (@(posedge iACLK) disable iff (iARST)
		o_arvalid && !i_arready |=> o_arvalid);
	a_run_done: assert property (@(posedge iACLK) disable iff (iARST)
		!(r_run && r_done));
	// address generator flags the last beat after exactly one pass of beats
	a_last_beat: assert property (@(posedge iACLK) disable iff (iARST)
		(o_bresp_take || o_rdata_take) |-> (i_last_beat == (r_beat_cnt == L_LAST_CNT)));

endmodule

/* design/mem_test_top.sv */
//--------------------------------------
// AXI4 DDR tester, single-beat id 0 transfers, full strobes
// wdata/rdata are P_DATA_W wide, no padding to the bus width
//--------------------------------------
`timescale 1ns/10ps

module mem_test_top #(
	parameter int          P_DATA_W          = 16,
	parameter int          P_START_BEAT      = 0,
	parameter int          P_STOP_BEAT       = 1023,
	parameter int          P_BANK_INTERLEAVE = 0,
	parameter logic [31:0] P_SEED            = 32'h0000_ace1
)(
	input  logic                            iACLK,
	input  logic                            iARST,
	input  logic                            i_cfg_done,
	// write address / data / response
	output logic [mem_test_pkg::ADDR_W-1:0] o_awaddr,
	output logic                            o_awvalid,
	input  logic                            i_awready,
	output logic [7:0]                      o_awlen,
	output logic [P_DATA_W-1:0]             o_wdata,
	output logic                            o_wlast,
	output logic                            o_wvalid,
	input  logic                            i_wready,
	input  logic                            i_bvalid,
	input  logic [1:0]                      i_bresp,
	output logic                            o_bready,
	// read address / data
	output logic [mem_test_pkg::ADDR_W-1:0] o_araddr,
	output logic                            o_arvalid,
	input  logic                            i_arready,
	output logic [7:0]                      o_arlen,
	input  logic                            i_rvalid,
	input  logic [1:0]                      i_rresp,
	input  logic [P_DATA_W-1:0]             i_rdata,
	output logic                            o_rready,
	// status
	output logic                            o_test_run,
	output logic                            o_test_done,
	output logic                            o_test_fail,
	// first error record
	output mem_test_pkg::err_kind_e         o_err_kind,
	output logic [mem_test_pkg::ADDR_W-1:0] o_err_addr,
	output logic [P_DATA_W-1:0]             o_err_exp,
	output logic [P_DATA_W-1:0]             o_err_act
);

	logic [mem_test_pkg::ADDR_W-1:0] addr;
	logic [P_DATA_W-1:0]             exp_data;
	logic                            last_beat;
	logic                            err;
	logic                            step_wr;
	logic                            bresp_take;
	logic                            rdata_take;
	logic                            restart;
	logic                            addr_step;
	logic                            pat_step;

	//--------------------------------------
	// fixed protocol fields
	//--------------------------------------
	// single beat, len 0 means one transfer
	assign o_awlen  = 8'd0;
	assign o_arlen  = 8'd0;
	assign o_wlast  = 1'b1;
	// one address serves both passes
	assign o_awaddr = addr;
	assign o_araddr = addr;
	assign o_wdata  = exp_data;

	// address moves once the beat is closed, held on the last one
	assign addr_step = (bresp_take || rdata_take) && !last_beat;
	// data moves once wdata is accepted, or after the compare
	assign pat_step  = step_wr || rdata_take;

	mem_test_ctrl #(
		.P_START_BEAT (P_START_BEAT),
		.P_STOP_BEAT  (P_STOP_BEAT)
	) mem_test_ctrl_i (
		.iACLK        (iACLK),
		.iARST        (iARST),
		.i_cfg_done   (i_cfg_done),
		.i_awready    (i_awready),
		.i_wready     (i_wready),
		.i_bvalid     (i_bvalid),
		.i_arready    (i_arready),
		.i_rvalid     (i_rvalid),
		.i_last_beat  (last_beat),
		.i_err        (err),
		.o_awvalid    (o_awvalid),
		.o_wvalid     (o_wvalid),
		.o_bready     (o_bready),
		.o_arvalid    (o_arvalid),
		.o_rready     (o_rready),
		.o_step_wr    (step_wr),
		.o_bresp_take (bresp_take),
		.o_rdata_take (rdata_take),
		.o_restart    (restart),
		.o_test_run   (o_test_run),
		.o_test_done  (o_test_done),
		.o_test_fail  (o_test_fail)
	);

	mem_addr_gen #(
		.P_START_BEAT      (P_START_BEAT),
		.P_STOP_BEAT       (P_STOP_BEAT),
		.P_BANK_INTERLEAVE (P_BANK_INTERLEAVE)
	) mem_addr_gen_i (
		.iACLK       (iACLK),
		.iARST       (iARST),
		.i_restart   (restart),
		.i_step      (addr_step),
		.o_addr      (addr),
		.o_last_beat (last_beat)
	);

	mem_pattern_gen #(
		.P_DATA_W (P_DATA_W),
		.P_SEED   (P_SEED)
	) mem_pattern_gen_i (
		.iACLK     (iACLK),
		.iARST     (iARST),
		.i_restart (restart),
		.i_step    (pat_step),
		.o_data    (exp_data)
	);

	mem_read_check #(
		.P_DATA_W (P_DATA_W)
	) mem_read_check_i (
		.iACLK        (iACLK),
		.iARST        (iARST),
		.i_bresp_take (bresp_take),
		.i_bresp      (i_bresp),
		.i_rdata_take (rdata_take),
		.i_rresp      (i_rresp),
		.i_rdata      (i_rdata),
		.i_exp_data   (exp_data),
		.i_addr       (addr),
		.o_err        (err),
		.o_err_kind   (o_err_kind),
		.o_err_addr   (o_err_addr),
		.o_err_exp    (o_err_exp),
		.o_err_act    (o_err_act)
	);

endmodule

/* tests/tb_mem_test.sv */
//----------------------------------------
// random-delay AXI slave around the tester, fixed seed, interleave 1
// four runs with a reset before each, clean, data flip, write and read SLVERR
//----------------------------------------
`timescale 1ns/10ps

module tb_mem_test;

	localparam int DW = 16;
	localparam int AW = mem_test_pkg::ADDR_W;
	localparam int START = 40;
	localparam int STOP = 55;
	localparam int BEATS = STOP - START + 1;
	localparam int RUNS = 4;
	// beats x 2 passes x 10 cycles x runs
	localparam int LIMIT = BEATS * 2 * 10 * RUNS;
	localparam logic [31:0] SEED = 32'h1357_9bdf;
	localparam int FLIP_BIT = 3;

	logic iACLK;
	logic iARST;
	logic i_cfg_done;
	logic [AW-1:0] o_awaddr;
	logic o_awvalid;
	logic i_awready = 1'b0;
	logic [7:0] o_awlen;
	logic [DW-1:0] o_wdata;
	logic o_wlast;
	logic o_wvalid;
	logic i_wready = 1'b0;
	logic i_bvalid = 1'b0;
	logic [1:0] i_bresp = 2'b00;
	logic o_bready;
	logic [AW-1:0] o_araddr;
	logic o_arvalid;
	logic i_arready = 1'b0;
	logic [7:0] o_arlen;
	logic i_rvalid = 1'b0;
	logic [1:0] i_rresp = 2'b00;
	logic [DW-1:0] i_rdata = '0;
	logic o_rready;
	logic o_test_run;
	logic o_test_done;
	logic o_test_fail;
	mem_test_pkg::err_kind_e o_err_kind;
	logic [AW-1:0] o_err_addr;
	logic [DW-1:0] o_err_exp;
	logic [DW-1:0] o_err_act;

	integer seed = 32'h30e5e762;
	int cycle_cnt = 0;
	// model address map and LFSR data per beat index
	logic [AW-1:0] exp_addr [BEATS];
	logic [DW-1:0] exp_data [BEATS];
	// injected fault beat index or -1 for none
	int flip_beat = -1;
	int wr_err_beat = -1;
	int rd_err_beat = -1;
	// slave state
	logic [DW-1:0] mem [logic [AW-1:0]];
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	logic [DW-1:0] wr_data;
	logic [DW-1:0] rdata_v;
	logic got_aw;
	logic got_w;
	logic b_busy;
	logic r_busy;
	int aw_cnt;
	int w_cnt;
	int ar_cnt;
	int b_cnt;
	int r_cnt;
	int b_idx;
	int r_idx;
	// port monitor state
	logic aw_pend;
	logic w_pend;
	logic ar_pend;
	logic [AW-1:0] aw_held;
	logic [AW-1:0] ar_held;
	logic [DW-1:0] w_held;
	int aw_n;
	int w_n;
	int ar_n;
	int b_n;
	int r_n;
	bit wr_seen [logic [AW-1:0]];
	bit rd_seen [logic [AW-1:0]];

	mem_test_top #(
		.P_DATA_W          (DW),
		.P_START_BEAT      (START),
		.P_STOP_BEAT       (STOP),
		.P_BANK_INTERLEAVE (1),
		.P_SEED            (SEED)
	) mem_test_top_i (.*);

	//----------------------------------------
	// model and checks
	//----------------------------------------
	// bank lowest, then col, row, cs
	function automatic logic [AW-1:0] beat_to_addr(input int idx);
		logic [30:0] b;
		b = 31'(START + idx);
		return {b[30], b[29:13], b[2:0], b[12:3], 2'b00};
	endfunction

	// galois form with taps 32'h80200003
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic kind_check(input mem_test_pkg::err_kind_e got,
		input mem_test_pkg::err_kind_e exp, input string what);
		if (got != exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %s, expected %s",
				$time, what, got.name(), exp.name()));
	endtask

	task automatic addr_check(input logic [AW-1:0] got, input logic [AW-1:0] exp,
		input string what);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic data_check(input logic [DW-1:0] got, input logic [DW-1:0] exp,
		input string what);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic bit_check(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic count_check(input int got, input int exp, input string what);
		if (got != exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// reset, idle without cfg_done, then run to done
	task automatic run_once(input int flip_b, input int wr_b, input int rd_b);
		flip_beat = flip_b;
		wr_err_beat = wr_b;
		rd_err_beat = rd_b;
		@(posedge iACLK);
		iARST <= 1'b1;
		i_cfg_done <= 1'b0;
		repeat (2)
			@(posedge iACLK);
		iARST <= 1'b0;
		repeat (6)
		begin
			@(negedge iACLK);
			bit_check(o_test_run || o_test_done || o_test_fail, 1'b0, "status before cfg_done");
			bit_check(o_awvalid || o_wvalid || o_arvalid, 1'b0, "valid before cfg_done");
			bit_check(o_bready || o_rready, 1'b0, "ready before cfg_done");
		end
		@(posedge iACLK);
		i_cfg_done <= 1'b1;
		// run rises at the edge that samples cfg_done
		@(posedge iACLK);
		@(negedge iACLK);
		while (!o_test_done)
		begin
			bit_check(o_test_run, 1'b1, "run while testing");
			@(negedge iACLK);
		end
		// the monitor flags any valid in this quiet tail
		repeat (4)
			@(negedge iACLK);
		bit_check(o_test_done, 1'b1, "done");
		bit_check(o_test_run, 1'b0, "run after done");
	endtask

	initial
	begin
		iACLK = 1'b0;
		forever
			#2 iACLK = ~iACLK;
	end

	always @(posedge iACLK)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT)
			stop_on_error($sformatf("timeout: no result within %0d cycles", LIMIT));
	end

	//----------------------------------------
	// AXI slave with random 0..3 cycle gaps
	//----------------------------------------
	always @(posedge iACLK)
	begin
		if (iARST)
		begin
			i_awready <= 1'b0;
			i_wready <= 1'b0;
			i_arready <= 1'b0;
			i_bvalid <= 1'b0;
			i_rvalid <= 1'b0;
			got_aw = 1'b0;
			got_w = 1'b0;
			b_busy = 1'b0;
			r_busy = 1'b0;
			aw_cnt = 0;
			w_cnt = 0;
			ar_cnt = 0;
			b_idx = 0;
			r_idx = 0;
		end
		else
		begin
			// ready comes back a random gap after each transfer
			if (o_awvalid && i_awready)
			begin
				wr_addr = o_awaddr;
				got_aw = 1'b1;
				aw_cnt = $random(seed) & 3;
				i_awready <= (aw_cnt == 0);
			end
			else if (!i_awready)
			begin
				i_awready <= (aw_cnt <= 1);
				aw_cnt = aw_cnt - 1;
			end
			if (o_wvalid && i_wready)
			begin
				wr_data = o_wdata;
				got_w = 1'b1;
				w_cnt = $random(seed) & 3;
				i_wready <= (w_cnt == 0);
			end
			else if (!i_wready)
			begin
				i_wready <= (w_cnt <= 1);
				w_cnt = w_cnt - 1;
			end
			if (got_aw && got_w && !b_busy)
			begin
				mem[wr_addr] = wr_data;
				b_busy = 1'b1;
				b_cnt = $random(seed) & 3;
			end
			if (i_bvalid && o_bready)
			begin
				i_bvalid <= 1'b0;
				b_busy = 1'b0;
				got_aw = 1'b0;
				got_w = 1'b0;
				b_idx = b_idx + 1;
			end
			else if (b_busy && !i_bvalid)
			begin
				if (b_cnt == 0)
				begin
					i_bvalid <= 1'b1;
					i_bresp <= (b_idx == wr_err_beat) ? mem_test_pkg::SLVERR : mem_test_pkg::OKAY;
				end
				else
					b_cnt = b_cnt - 1;
			end
			if (o_arvalid && i_arready)
			begin
				rd_addr = o_araddr;
				r_busy = 1'b1;
				r_cnt = $random(seed) & 3;
				ar_cnt = $random(seed) & 3;
				i_arready <= (ar_cnt == 0);
			end
			else if (!i_arready)
			begin
				i_arready <= (ar_cnt <= 1);
				ar_cnt = ar_cnt - 1;
			end
			if (i_rvalid && o_rready)
			begin
				i_rvalid <= 1'b0;
				r_busy = 1'b0;
				r_idx = r_idx + 1;
			end
			else if (r_busy && !i_rvalid)
			begin
				if (r_cnt != 0)
					r_cnt = r_cnt - 1;
				else if (!mem.exists(rd_addr))
					stop_on_error($sformatf("read of address %h that was never written", rd_addr));
				else
				begin
					rdata_v = mem[rd_addr];
					// single bit fault on the chosen read beat
					if (r_idx == flip_beat)
						rdata_v = rdata_v ^ DW'(1 << FLIP_BIT);
					i_rdata <= rdata_v;
					i_rresp <= (r_idx == rd_err_beat) ? mem_test_pkg::SLVERR : mem_test_pkg::OKAY;
					i_rvalid <= 1'b1;
				end
			end
		end
	end

	//----------------------------------------
	// port monitor
	//----------------------------------------
	always @(posedge iACLK)
	begin
		if (iARST)
		begin
			aw_pend = 1'b0;
			w_pend = 1'b0;
			ar_pend = 1'b0;
			aw_n = 0;
			w_n = 0;
			ar_n = 0;
			b_n = 0;
			r_n = 0;
			wr_seen.delete();
			rd_seen.delete();
		end
		else
		begin
			// a pending valid stays up with its payload frozen
			if (aw_pend)
			begin
				bit_check(o_awvalid, 1'b1, "awvalid before transfer");
				addr_check(o_awaddr, aw_held, "awaddr before transfer");
			end
			if (w_pend)
			begin
				bit_check(o_wvalid, 1'b1, "wvalid before transfer");
				data_check(o_wdata, w_held, "wdata before transfer");
			end
			if (ar_pend)
			begin
				bit_check(o_arvalid, 1'b1, "arvalid before transfer");
				addr_check(o_araddr, ar_held, "araddr before transfer");
			end
			aw_pend = o_awvalid && !i_awready;
			w_pend = o_wvalid && !i_wready;
			ar_pend = o_arvalid && !i_arready;
			aw_held = o_awaddr;
			w_held = o_wdata;
			ar_held = o_araddr;
			if (o_test_done)
			begin
				bit_check(o_awvalid || o_wvalid || o_arvalid, 1'b0, "valid after done");
				bit_check(o_bready || o_rready, 1'b0, "ready after done");
			end
			if (o_awvalid && i_awready)
			begin
				if (aw_n >= BEATS || wr_seen.exists(o_awaddr))
					stop_on_error($sformatf("address %h written twice or past the range", o_awaddr));
				else
				begin
					addr_check(o_awaddr, exp_addr[aw_n], "awaddr");
					count_check(int'(o_awlen), 0, "awlen");
					wr_seen[o_awaddr] = 1'b1;
					aw_n = aw_n + 1;
				end
			end
			if (o_wvalid && i_wready)
			begin
				if (w_n >= BEATS)
					stop_on_error("more write data beats than beats in the range");
				else
				begin
					data_check(o_wdata, exp_data[w_n], "wdata");
					bit_check(o_wlast, 1'b1, "wlast");
					w_n = w_n + 1;
				end
			end
			if (o_arvalid && i_arready)
			begin
				if (ar_n >= BEATS || rd_seen.exists(o_araddr))
					stop_on_error($sformatf("address %h read twice or past the range", o_araddr));
				else
				begin
					addr_check(o_araddr, exp_addr[ar_n], "araddr");
					count_check(int'(o_arlen), 0, "arlen");
					rd_seen[o_araddr] = 1'b1;
					ar_n = ar_n + 1;
				end
			end
			if (i_bvalid && o_bready)
				b_n = b_n + 1;
			if (i_rvalid && o_rready)
				r_n = r_n + 1;
		end
	end

	//----------------------------------------
	// test sequence
	//----------------------------------------
	initial
	begin
		logic [31:0] s;
		iARST <= 1'b1;
		i_cfg_done <= 1'b0;
		s = SEED;
		for (int k = 0; k < BEATS; k++)
		begin
			exp_addr[k] = beat_to_addr(k);
			exp_data[k] = s[DW-1:0];
			s = lfsr_step(s);
		end
		// clean pass over the whole range
		run_once(-1, -1, -1);
		bit_check(o_test_fail, 1'b0, "fail, clean run");
		kind_check(o_err_kind, mem_test_pkg::ERR_NONE, "error kind, clean run");
		count_check(b_n, BEATS, "write count, clean run");
		count_check(r_n, BEATS, "read count, clean run");
		// one bit flipped on read beat 5
		run_once(5, -1, -1);
		bit_check(o_test_fail, 1'b1, "fail, data flip");
		kind_check(o_err_kind, mem_test_pkg::ERR_DATA, "error kind, data flip");
		addr_check(o_err_addr, exp_addr[5], "error address, data flip");
		data_check(o_err_exp, exp_data[5], "expected data, data flip");
		data_check(o_err_act, exp_data[5] ^ DW'(1 << FLIP_BIT), "actual data, data flip");
		count_check(ar_n, 6, "reads issued, data flip");
		// SLVERR on write beat 9
		run_once(-1, 9, -1);
		bit_check(o_test_fail, 1'b1, "fail, write error");
		kind_check(o_err_kind, mem_test_pkg::ERR_WRESP, "error kind, write error");
		addr_check(o_err_addr, exp_addr[9], "error address, write error");
		count_check(ar_n, 0, "reads issued, write error");
		// SLVERR on read beat 12
		run_once(-1, -1, 12);
		bit_check(o_test_fail, 1'b1, "fail, read error");
		kind_check(o_err_kind, mem_test_pkg::ERR_RRESP, "error kind, read error");
		addr_check(o_err_addr, exp_addr[12], "error address, read error");
		count_check(ar_n, 13, "reads issued, read error");
		$display("TEST PASS");
		$finish;
	end

endmodule

/* src.f */
design/mem_test_pkg.sv
design/mem_addr_gen.sv
design/mem_pattern_gen.sv
design/mem_read_check.sv
design/mem_test_ctrl.sv
design/mem_test_top.sv
tests/tb_mem_test.sv

/* Makefile */
# Verilator build and run for the DDR memory tester
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_mem_test
FILES   = src.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)

# pass only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
